//--- hdl/i3c_target_pkg.sv
// Shared definitions of the I3C target primary controller
// Bus byte and target address widths and their types
// Broadcast address byte and the primary FSM state encoding

`default_nettype none

package i3c_target_pkg;

  // Bits in one bus byte
  localparam int unsigned BYTE_W = 8;

  // Bits in a 7-bit I3C target address
  localparam int unsigned ADDR_W = 7;

  typedef logic [BYTE_W-1:0] byte_t;
  typedef logic [ADDR_W-1:0] addr_t;

  // Address 7E with the write bit, the I3C broadcast header
  localparam byte_t BCAST_BYTE = 8'hFC;

  // Primary controller states
  typedef enum logic [3:0] {
    Idle,
    RxFByte,
    CheckFByte,
    TxAckFByte,
    RxSByte,
    RxSByteRepeated,
    CheckSByte,
    TxAckSByte,
    RxPWriteData,
    RxPWriteTbit,
    TxPReadData,
    TxPReadTbit,
    Wait
  } target_state_e;

endpackage : i3c_target_pkg

`default_nettype wire

//--- hdl/xfer_ctrl_if.sv
// Control strobes from the primary FSM to the address decoder
// and to the receive and transmit datapaths

`default_nettype none
`timescale 1ns/100ps

interface xfer_ctrl_if;

  logic addr_capture;  // Address byte received
  logic xfer_idle;     // Level, FSM sits in Idle
  logic tbit_check;    // Write T-bit received
  logic wr_commit;     // Leaving the write T-bit state
  logic wr_enter;      // Entering the write data state
  logic rd_fetch;      // First cycle of a read data byte
  logic tx_sel_ack;    // Level, ACK bit is being sent
  logic tx_sel_tbit;   // Level, read T-bit is being sent

  modport fsm(
    output addr_capture, xfer_idle, tbit_check, wr_commit,
    output wr_enter, rd_fetch, tx_sel_ack, tx_sel_tbit
  );

  modport dec(input addr_capture, xfer_idle);

  modport rx(input xfer_idle, tbit_check, wr_commit, wr_enter);

  modport tx(input rd_fetch, tx_sel_ack, tx_sel_tbit);

endinterface : xfer_ctrl_if

`default_nettype wire

//--- hdl/target_fsm.sv
// Primary state machine of the I3C target
// Address phase, ACK, private write and read loops, Wait state
// PHY request levels, datapath strobes and status outputs

`default_nettype none
`timescale 1ns/100ps

module target_fsm (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic target_enable_i,
  input  logic bus_start_det_i,
  input  logic bus_rstart_det_i,
  input  logic bus_stop_det_i,
  input  logic bus_rx_done_i,
  input  logic bus_tx_done_i,
  input  logic tx_fifo_rvalid_i,
  input  logic own_match_i,
  input  logic bcast_match_i,
  input  logic rnw_i,
  input  logic tx_last_i,
  output logic bus_rx_req_byte_o,
  output logic bus_rx_req_bit_o,
  output logic bus_tx_req_byte_o,
  output logic bus_tx_req_bit_o,
  output logic rx_last_byte_o,
  output logic target_idle_o,
  output logic target_transmitting_o,
  output logic event_target_nack_o,
  xfer_ctrl_if.fsm ctrl
);
  import i3c_target_pkg::*;

  target_state_e state_q, state_d;
  logic bus_start_det;
  logic rd_fetch_q;

  // START and repeated START are handled alike
  assign bus_start_det = bus_start_det_i | bus_rstart_det_i;

  always_comb begin
    state_d = state_q;
    case (state_q)
      Idle: begin
        if (target_enable_i && bus_start_det) state_d = RxFByte;
      end
      RxFByte: begin
        if (bus_rx_done_i) state_d = CheckFByte;
      end
      // One cycle for the decoder to compare the captured byte
      CheckFByte: begin
        if (bcast_match_i || own_match_i) state_d = TxAckFByte;
        else state_d = Wait;
      end
      TxAckFByte: begin
        if (bus_tx_done_i) begin
          if (bcast_match_i) state_d = RxSByte;
          else if (own_match_i && rnw_i) state_d = TxPReadData;
          else if (own_match_i) state_d = RxPWriteData;
          else state_d = Wait;
        end
      end
      // Data after the broadcast would be a CCC, which is not followed
      RxSByte: begin
        if (bus_start_det) state_d = RxSByteRepeated;
        else if (bus_rx_done_i) state_d = Wait;
      end
      RxSByteRepeated: begin
        if (bus_rx_done_i) state_d = CheckSByte;
      end
      CheckSByte: begin
        if (own_match_i) state_d = TxAckSByte;
        else state_d = Wait;
      end
      TxAckSByte: begin
        if (bus_tx_done_i) begin
          if (rnw_i) state_d = TxPReadData;
          else state_d = RxPWriteData;
        end
      end
      // Private write loop
      RxPWriteData: begin
        if (bus_start_det) state_d = RxFByte;
        else if (bus_stop_det_i) state_d = Idle;
        else if (bus_rx_done_i) state_d = RxPWriteTbit;
      end
      RxPWriteTbit: begin
        if (bus_rx_done_i) state_d = RxPWriteData;
      end
      // Private read loop
      TxPReadData: begin
        if (bus_start_det) state_d = RxFByte;
        else if (bus_stop_det_i) state_d = Idle;
        else if (bus_tx_done_i) state_d = TxPReadTbit;
      end
      // Carry on only with more data and no last mark on the byte just sent
      TxPReadTbit: begin
        if (bus_tx_done_i) begin
          if (!tx_last_i && tx_fifo_rvalid_i) state_d = TxPReadData;
          else state_d = Wait;
        end
      end
      // Not for us, follow the bus to the next START or STOP
      Wait: begin
        if (bus_start_det) state_d = RxFByte;
        else if (bus_stop_det_i) state_d = Idle;
      end
      default: state_d = Idle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= Idle;
      rd_fetch_q <= 1'b0;
    end else begin
      state_q    <= state_d;
      // Marks the first cycle spent in TxPReadData
      rd_fetch_q <= (state_d == TxPReadData) && (state_q != TxPReadData);
    end
  end

  // Byte reception, dropped while a new START is being flagged
  assign bus_rx_req_byte_o =
    ((state_q inside {RxFByte, RxSByte, RxSByteRepeated}) && !bus_start_det) ||
    (state_q == RxPWriteData);
  assign bus_rx_req_bit_o  = (state_q == RxPWriteTbit);
  assign bus_tx_req_byte_o = (state_q == TxPReadData);
  assign bus_tx_req_bit_o  = (state_q inside {TxAckFByte, TxAckSByte, TxPReadTbit});

  // Strobes towards decoder and datapaths
  assign ctrl.addr_capture = bus_rx_done_i &&
                             (state_q inside {RxFByte, RxSByte, RxSByteRepeated});
  assign ctrl.xfer_idle    = (state_q == Idle);
  assign ctrl.tbit_check   = bus_rx_done_i && (state_q == RxPWriteTbit);
  assign ctrl.wr_commit    = (state_q == RxPWriteTbit) && (state_d != RxPWriteTbit);
  assign ctrl.wr_enter     = (state_d == RxPWriteData) && (state_q != RxPWriteData);
  assign ctrl.rd_fetch     = rd_fetch_q;
  assign ctrl.tx_sel_ack   = (state_q inside {TxAckFByte, TxAckSByte});
  assign ctrl.tx_sel_tbit  = (state_q == TxPReadTbit);

  // End of the write loop by START or STOP
  assign rx_last_byte_o = (state_q == RxPWriteData) && (state_d inside {RxFByte, Idle});

  assign target_idle_o = (state_q == Idle);
  assign target_transmitting_o =
    (state_q inside {TxAckFByte, TxAckSByte, TxPReadData, TxPReadTbit});

  // One pulse per transfer that is NACKed
  assign event_target_nack_o = (state_d == Wait) && (state_q != Wait);

endmodule : target_fsm

`default_nettype wire

//--- hdl/addr_decoder.sv
// Address decoder of the I3C target
// Captures address and RnW of the header byte
// Own-address match with dynamic over static precedence, broadcast match

`default_nettype none
`timescale 1ns/100ps

module addr_decoder (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  i3c_target_pkg::byte_t bus_rx_data_i,
  input  i3c_target_pkg::addr_t target_sta_address_i,
  input  i3c_target_pkg::addr_t target_dyn_address_i,
  input  logic                  target_sta_address_valid_i,
  input  logic                  target_dyn_address_valid_i,
  xfer_ctrl_if.dec              ctrl,
  output logic                  own_match_o,
  output logic                  bcast_match_o,
  output logic                  rnw_o
);
  import i3c_target_pkg::*;

  addr_t addr_q;
  logic  rnw_q;

  // Upper seven bits are the address, bit 0 is RnW
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end else if (ctrl.addr_capture) begin
      addr_q <= bus_rx_data_i[BYTE_W-1:1];
      rnw_q  <= bus_rx_data_i[0];
    end else if (ctrl.xfer_idle) begin
      addr_q <= '0;
      rnw_q  <= 1'b0;
    end
  end

  // Dynamic address wins once assigned
  // Without any address the target never matches
  always_comb begin
    if (target_dyn_address_valid_i) own_match_o = (addr_q == target_dyn_address_i);
    else if (target_sta_address_valid_i) own_match_o = (addr_q == target_sta_address_i);
    else own_match_o = 1'b0;
  end

  // Whole byte compare, a read to 7E is not the broadcast
  assign bcast_match_o = ({addr_q, rnw_q} == BCAST_BYTE);
  assign rnw_o         = rnw_q;

endmodule : addr_decoder

`default_nettype wire

//--- hdl/rx_datapath.sv
// Receive datapath of the I3C target
// Data byte register and T-bit odd parity check
// Parity and overflow error latches, RX FIFO write

`default_nettype none
`timescale 1ns/100ps

module rx_datapath (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [7:0] bus_rx_data_i,
  input  logic       bus_rx_done_i,
  input  logic       rx_fifo_wready_i,
  xfer_ctrl_if.rx    ctrl,
  output logic       rx_fifo_wvalid_o,
  output logic [7:0] rx_fifo_wdata_o,
  output logic       parity_err_o,
  output logic       rx_overflow_err_o
);

  logic [7:0] rx_byte_q;
  logic       parity_fail;
  logic       parity_err_q;
  logic       ovf_q;
  logic       ovf_dly_q;
  logic       wvalid_q;

  // Every received byte, the T-bit itself is kept out
  always_ff @(posedge clk_i) begin
    if (bus_rx_done_i && !ctrl.tbit_check) rx_byte_q <= bus_rx_data_i;
  end

  // T-bit arrives in bit 0 and makes the count of ones odd
  assign parity_fail  = ctrl.tbit_check && (bus_rx_data_i[0] != ~^rx_byte_q);
  assign parity_err_o = parity_fail;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      parity_err_q <= 1'b0;
    end else if (parity_fail) begin
      parity_err_q <= 1'b1;
    end else if (ctrl.xfer_idle) begin
      parity_err_q <= 1'b0;
    end
  end

  // FIFO full when a data byte is about to start
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ovf_q     <= 1'b0;
      ovf_dly_q <= 1'b0;
    end else begin
      ovf_dly_q <= ovf_q;
      if (ctrl.wr_enter && !rx_fifo_wready_i) ovf_q <= 1'b1;
      else if (ctrl.xfer_idle) ovf_q <= 1'b0;
    end
  end

  // Rising edge only
  assign rx_overflow_err_o = ovf_q && !ovf_dly_q;

  // Write one cycle after the T-bit, only for a clean transfer
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wvalid_q <= 1'b0;
    end else begin
      wvalid_q <= ctrl.wr_commit && !(parity_fail || parity_err_q || ovf_q);
    end
  end

  assign rx_fifo_wvalid_o = wvalid_q;
  assign rx_fifo_wdata_o  = rx_byte_q;

endmodule : rx_datapath

`default_nettype wire

//--- hdl/tx_datapath.sv
// Transmit datapath of the I3C target
// TX FIFO pop with data byte and last flag capture
// Transmit value select for ACK, read T-bit and data

`default_nettype none
`timescale 1ns/100ps

module tx_datapath (
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic [7:0] tx_fifo_rdata_i,
  input  logic       tx_last_byte_i,
  xfer_ctrl_if.tx    ctrl,
  output logic       tx_fifo_rready_o,
  output logic [7:0] bus_tx_req_value_o,
  output logic       tx_last_o
);

  logic [7:0] tx_byte_q;
  logic       tx_last_q;
  logic [7:0] data_value;

  // One pop per read byte, in its first request cycle
  assign tx_fifo_rready_o = ctrl.rd_fetch;

  always_ff @(posedge clk_i) begin
    if (ctrl.rd_fetch) tx_byte_q <= tx_fifo_rdata_i;
  end

  // Last mark travels with its byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      tx_last_q <= 1'b0;
    end else if (ctrl.rd_fetch) begin
      tx_last_q <= tx_last_byte_i;
    end
  end

  // FIFO head is shown directly in the pop cycle
  assign data_value = ctrl.rd_fetch ? tx_fifo_rdata_i : tx_byte_q;

  always_comb begin
    if (ctrl.tx_sel_ack) begin
      bus_tx_req_value_o = 8'h00;
    end else if (ctrl.tx_sel_tbit) begin
      // T-bit high means more data follows
      bus_tx_req_value_o = {7'h00, ~tx_last_q};
    end else begin
      bus_tx_req_value_o = data_value;
    end
  end

  assign tx_last_o = tx_last_q;

endmodule : tx_datapath

`default_nettype wire

//--- hdl/i3c_target_ctrl.sv
// Top level of the I3C target primary controller
// Primary FSM, address decoder, RX and TX datapaths
// joined by the transfer control interface

`default_nettype none
`timescale 1ns/100ps

module i3c_target_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  target_enable_i,
  // Bus condition detectors
  input  logic                  bus_start_det_i,
  input  logic                  bus_rstart_det_i,
  input  logic                  bus_stop_det_i,
  // PHY handshake
  input  logic                  bus_rx_done_i,
  input  i3c_target_pkg::byte_t bus_rx_data_i,
  input  logic                  bus_tx_done_i,
  output logic                  bus_rx_req_byte_o,
  output logic                  bus_rx_req_bit_o,
  output logic                  bus_tx_req_byte_o,
  output logic                  bus_tx_req_bit_o,
  output i3c_target_pkg::byte_t bus_tx_req_value_o,
  // RX FIFO for private writes
  output logic                  rx_fifo_wvalid_o,
  output i3c_target_pkg::byte_t rx_fifo_wdata_o,
  input  logic                  rx_fifo_wready_i,
  output logic                  rx_last_byte_o,
  // TX FIFO for private reads
  input  logic                  tx_fifo_rvalid_i,
  output logic                  tx_fifo_rready_o,
  input  i3c_target_pkg::byte_t tx_fifo_rdata_i,
  input  logic                  tx_last_byte_i,
  // Target addresses
  input  i3c_target_pkg::addr_t target_sta_address_i,
  input  i3c_target_pkg::addr_t target_dyn_address_i,
  input  logic                  target_sta_address_valid_i,
  input  logic                  target_dyn_address_valid_i,
  // Status, events and errors
  output logic                  target_idle_o,
  output logic                  target_transmitting_o,
  output logic                  event_target_nack_o,
  output logic                  parity_err_o,
  output logic                  rx_overflow_err_o
);

  logic own_match;
  logic bcast_match;
  logic rnw;
  logic tx_last;

  xfer_ctrl_if ctrl ();

  target_fsm u_fsm (
    .clk_i                 (clk_i),
    .rst_ni                (rst_ni),
    .target_enable_i       (target_enable_i),
    .bus_start_det_i       (bus_start_det_i),
    .bus_rstart_det_i      (bus_rstart_det_i),
    .bus_stop_det_i        (bus_stop_det_i),
    .bus_rx_done_i         (bus_rx_done_i),
    .bus_tx_done_i         (bus_tx_done_i),
    .tx_fifo_rvalid_i      (tx_fifo_rvalid_i),
    .own_match_i           (own_match),
    .bcast_match_i         (bcast_match),
    .rnw_i                 (rnw),
    .tx_last_i             (tx_last),
    .bus_rx_req_byte_o     (bus_rx_req_byte_o),
    .bus_rx_req_bit_o      (bus_rx_req_bit_o),
    .bus_tx_req_byte_o     (bus_tx_req_byte_o),
    .bus_tx_req_bit_o      (bus_tx_req_bit_o),
    .rx_last_byte_o        (rx_last_byte_o),
    .target_idle_o         (target_idle_o),
    .target_transmitting_o (target_transmitting_o),
    .event_target_nack_o   (event_target_nack_o),
    .ctrl                  (ctrl.fsm)
  );

  addr_decoder u_dec (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .bus_rx_data_i              (bus_rx_data_i),
    .target_sta_address_i       (target_sta_address_i),
    .target_dyn_address_i       (target_dyn_address_i),
    .target_sta_address_valid_i (target_sta_address_valid_i),
    .target_dyn_address_valid_i (target_dyn_address_valid_i),
    .ctrl                       (ctrl.dec),
    .own_match_o                (own_match),
    .bcast_match_o              (bcast_match),
    .rnw_o                      (rnw)
  );

  rx_datapath u_rx (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .bus_rx_data_i     (bus_rx_data_i),
    .bus_rx_done_i     (bus_rx_done_i),
    .rx_fifo_wready_i  (rx_fifo_wready_i),
    .ctrl              (ctrl.rx),
    .rx_fifo_wvalid_o  (rx_fifo_wvalid_o),
    .rx_fifo_wdata_o   (rx_fifo_wdata_o),
    .parity_err_o      (parity_err_o),
    .rx_overflow_err_o (rx_overflow_err_o)
  );

  tx_datapath u_tx (
    .clk_i              (clk_i),
    .rst_ni             (rst_ni),
    .tx_fifo_rdata_i    (tx_fifo_rdata_i),
    .tx_last_byte_i     (tx_last_byte_i),
    .ctrl               (ctrl.tx),
    .tx_fifo_rready_o   (tx_fifo_rready_o),
    .bus_tx_req_value_o (bus_tx_req_value_o),
    .tx_last_o          (tx_last)
  );

endmodule : i3c_target_ctrl

`default_nettype wire

//--- test/i3c_target_ctrl_assertions.sv
// Concurrent checks bound to the I3C target top level
// PHY request exclusivity, FIFO strobe width, return to idle on STOP
// Count of failed assertions

`default_nettype none
`timescale 1ns/100ps

module i3c_target_ctrl_assertions (
  input logic                          clk_i,
  input logic                          rst_ni,
  input logic                          start_i,
  input logic                          rstart_i,
  input logic                          stop_i,
  input logic                          rx_req_byte_i,
  input logic                          rx_req_bit_i,
  input logic                          tx_req_byte_i,
  input logic                          tx_req_bit_i,
  input logic                          wvalid_i,
  input logic                          rready_i,
  input logic                          idle_i,
  input i3c_target_pkg::target_state_e state_i
);
  import i3c_target_pkg::*;

  // Number of failed assertions
  int unsigned fail_cnt = 0;

  // The PHY serves one request at a time
  a_one_request: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $onehot0({rx_req_byte_i, rx_req_bit_i, tx_req_byte_i, tx_req_bit_i}))
    else begin
      fail_cnt++;
      $error("more than one PHY request is high");
    end

  // FIFO strobes are single-cycle
  a_wvalid_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    wvalid_i |=> !wvalid_i)
    else begin
      fail_cnt++;
      $error("rx_fifo_wvalid_o held for more than one cycle");
    end

  a_rready_pulse: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rready_i |=> !rready_i)
    else begin
      fail_cnt++;
      $error("tx_fifo_rready_o held for more than one cycle");
    end

  // START wins over STOP in Wait
  a_stop_to_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (state_i == Wait && stop_i && !start_i && !rstart_i) |=> idle_i)
    else begin
      fail_cnt++;
      $error("no return to idle after STOP in Wait");
    end

endmodule : i3c_target_ctrl_assertions

`default_nettype wire

//--- test/tb_i3c_target_ctrl.sv
// Testbench for the I3C target primary controller
// Clock, reset, PHY model, RX and TX FIFO models
// Transaction table applied in a loop, result checks per transaction

`default_nettype none
`timescale 1ns/100ps

module tb_i3c_target_ctrl;
  import i3c_target_pkg::*;

  localparam int TIMEOUT = 200;

  // Transaction kinds
  localparam logic [1:0] K_WR = 2'd0;  // Private write
  localparam logic [1:0] K_RD = 2'd1;  // Private read
  localparam logic [1:0] K_BC = 2'd2;  // Broadcast, repeated START, then private write
  localparam logic [1:0] K_MM = 2'd3;  // Not for this target

  localparam logic [2:0] NONE = 3'd7;

  localparam addr_t DYN_ADDR = 7'h2A;
  localparam addr_t STA_ADDR = 7'h51;
  localparam byte_t HDR_DYN_W = {DYN_ADDR, 1'b0};
  localparam byte_t HDR_DYN_R = {DYN_ADDR, 1'b1};
  localparam byte_t HDR_STA_W = {STA_ADDR, 1'b0};

  typedef struct packed {
    logic [1:0]  kind;
    logic [7:0]  hdr;
    logic [7:0]  hdr2;
    logic        dyn_v;
    logic        sta_v;
    logic        wready;
    logic [2:0]  nbytes;
    logic [31:0] data;      // Byte i in bits 8*i+7 down to 8*i
    logic [2:0]  bad_idx;   // Byte whose T-bit is corrupted
    logic [2:0]  last_idx;  // Read byte marked last in the TX FIFO
    logic [2:0]  exp_wr;
    logic        exp_nack;
    logic        exp_par;
    logic        exp_ovf;
  } txn_t;

  logic  clk_i;
  logic  rst_ni;
  logic  target_enable_i;
  logic  bus_start_det_i;
  logic  bus_rstart_det_i;
  logic  bus_stop_det_i;
  logic  bus_rx_done_i;
  byte_t bus_rx_data_i;
  logic  bus_tx_done_i;
  logic  bus_rx_req_byte_o;
  logic  bus_rx_req_bit_o;
  logic  bus_tx_req_byte_o;
  logic  bus_tx_req_bit_o;
  byte_t bus_tx_req_value_o;
  logic  rx_fifo_wvalid_o;
  byte_t rx_fifo_wdata_o;
  logic  rx_fifo_wready_i;
  logic  rx_last_byte_o;
  logic  tx_fifo_rvalid_i;
  logic  tx_fifo_rready_o;
  byte_t tx_fifo_rdata_i;
  logic  tx_last_byte_i;
  addr_t target_sta_address_i;
  addr_t target_dyn_address_i;
  logic  target_sta_address_valid_i;
  logic  target_dyn_address_valid_i;
  logic  target_idle_o;
  logic  target_transmitting_o;
  logic  event_target_nack_o;
  logic  parity_err_o;
  logic  rx_overflow_err_o;

  txn_t       rows [0:15];
  int         n_rows;
  integer     seed;
  int         errors;
  int         checks;
  byte_t      wr_got [$];
  byte_t      txd_got [$];
  byte_t      txb_got [$];
  logic [8:0] tx_q [$];
  logic       pop_req;
  logic       bit_req_q;
  int         nack_cnt;
  int         par_cnt;
  int         ovf_cnt;
  int         last_cnt;
  int         pop_cnt;
  int         bit_req_cnt;

  i3c_target_ctrl uut (.*);

  bind i3c_target_ctrl i3c_target_ctrl_assertions u_assertions (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .start_i       (bus_start_det_i),
    .rstart_i      (bus_rstart_det_i),
    .stop_i        (bus_stop_det_i),
    .rx_req_byte_i (bus_rx_req_byte_o),
    .rx_req_bit_i  (bus_rx_req_bit_o),
    .tx_req_byte_i (bus_tx_req_byte_o),
    .tx_req_bit_i  (bus_tx_req_bit_o),
    .wvalid_i      (rx_fifo_wvalid_o),
    .rready_i      (tx_fifo_rready_o),
    .idle_i        (target_idle_o),
    .state_i       (u_fsm.state_q)
  );

  initial clk_i = 1'b0;
  always #4 clk_i = ~clk_i;

  // Monitor, samples pre-edge values at the rising edge
  always @(posedge clk_i) begin
    if (rx_fifo_wvalid_o) wr_got.push_back(rx_fifo_wdata_o);
    if (bus_tx_done_i && bus_tx_req_byte_o) txd_got.push_back(bus_tx_req_value_o);
    if (bus_tx_done_i && bus_tx_req_bit_o) txb_got.push_back(bus_tx_req_value_o);
    if (bus_tx_req_bit_o && !bit_req_q) bit_req_cnt++;
    bit_req_q = bus_tx_req_bit_o;
    if (event_target_nack_o) nack_cnt++;
    if (parity_err_o) par_cnt++;
    if (rx_overflow_err_o) ovf_cnt++;
    if (rx_last_byte_o) last_cnt++;
    if (tx_fifo_rready_o) pop_cnt++;
  end

  // TX FIFO model, pop seen at the rising edge and applied at the falling edge
  always @(posedge clk_i) begin
    if (tx_fifo_rready_o) pop_req = 1'b1;
  end

  always @(negedge clk_i) begin
    if (pop_req && tx_q.size() > 0) tx_q.delete(0);
    pop_req = 1'b0;
    if (tx_q.size() > 0) begin
      {tx_last_byte_i, tx_fifo_rdata_i} = tx_q[0];
      tx_fifo_rvalid_i = 1'b1;
    end else begin
      {tx_last_byte_i, tx_fifo_rdata_i} = 9'h000;
      tx_fifo_rvalid_i = 1'b0;
    end
  end

  task automatic expect_equal(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("ERR at %0t ns: %s is %0h, expected %0h", $time, name, got, exp);
    end
  endtask

  task automatic end_of_test;
    errors += uut.u_assertions.fail_cnt;
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic abort_on_timeout(input string what);
    errors++;
    $display("Timeout: no %s within %0d clock cycles", what, TIMEOUT);
    end_of_test();
  endtask

  task automatic add_row(input logic [1:0] kind, input byte_t hdr, input byte_t hdr2,
                         input logic dyn_v, input logic sta_v, input logic wready,
                         input logic [2:0] nbytes, input logic [31:0] data,
                         input logic [2:0] bad_idx, input logic [2:0] last_idx,
                         input logic [2:0] exp_wr, input logic exp_nack,
                         input logic exp_par, input logic exp_ovf);
    rows[n_rows] = {kind, hdr, hdr2, dyn_v, sta_v, wready, nbytes, data,
                    bad_idx, last_idx, exp_wr, exp_nack, exp_par, exp_ovf};
    n_rows++;
  endtask

  // One-cycle bus condition, bits are START, repeated START, STOP
  task automatic drive_condition(input logic [2:0] cond);
    @(negedge clk_i);
    {bus_start_det_i, bus_rstart_det_i, bus_stop_det_i} = cond;
    @(negedge clk_i);
    {bus_start_det_i, bus_rstart_det_i, bus_stop_det_i} = 3'b000;
  endtask

  // PHY receive, answers a byte or bit request after a random delay
  task automatic serve_rx(input logic is_bit, input byte_t data);
    int n;
    int dly;
    n = 0;
    @(negedge clk_i);
    while (!(is_bit ? bus_rx_req_bit_o : bus_rx_req_byte_o) && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!(is_bit ? bus_rx_req_bit_o : bus_rx_req_byte_o))
      abort_on_timeout(is_bit ? "rx bit request" : "rx byte request");
    // Receiving is never flagged as transmitting
    expect_equal("target_transmitting_o", target_transmitting_o, 1'b0);
    dly = $unsigned($random(seed)) % 4;
    repeat (dly) @(negedge clk_i);
    bus_rx_data_i = data;
    bus_rx_done_i = 1'b1;
    @(negedge clk_i);
    bus_rx_done_i = 1'b0;
  endtask

  // PHY transmit, the value is picked up by the monitor with done
  task automatic serve_tx(input logic is_bit);
    int n;
    int dly;
    n = 0;
    @(negedge clk_i);
    while (!(is_bit ? bus_tx_req_bit_o : bus_tx_req_byte_o) && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!(is_bit ? bus_tx_req_bit_o : bus_tx_req_byte_o))
      abort_on_timeout(is_bit ? "tx bit request" : "tx byte request");
    // ACK and read data both drive the bus
    expect_equal("target_transmitting_o", target_transmitting_o, 1'b1);
    dly = $unsigned($random(seed)) % 4;
    repeat (dly) @(negedge clk_i);
    bus_tx_done_i = 1'b1;
    @(negedge clk_i);
    bus_tx_done_i = 1'b0;
  endtask

  task automatic wait_nack;
    int n;
    n = 0;
    while (nack_cnt == 0 && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (nack_cnt == 0) abort_on_timeout("NACK event");
  endtask

  task automatic wait_idle;
    int n;
    n = 0;
    while (!target_idle_o && n < TIMEOUT) begin
      @(negedge clk_i);
      n++;
    end
    if (!target_idle_o) abort_on_timeout("return to idle");
  endtask

  task automatic run_row(input int idx);
    txn_t  r;
    byte_t exp_bits [$];
    byte_t d;
    int    i;
    int    n_ack;
    int    n_rd;
    int    n_data;
    r = rows[idx];
    target_dyn_address_valid_i = r.dyn_v;
    target_sta_address_valid_i = r.sta_v;
    rx_fifo_wready_i = r.wready;
    wr_got.delete();
    txd_got.delete();
    txb_got.delete();
    {nack_cnt, par_cnt, ovf_cnt, last_cnt, pop_cnt, bit_req_cnt} = '0;

    n_ack = (r.kind == K_BC) ? 2 : ((r.kind == K_MM) ? 0 : 1);
    n_rd  = (r.kind == K_RD) ? r.nbytes : 0;
    // Reading ends after the byte marked last, the rest stays queued
    if (n_rd > r.last_idx) n_rd = r.last_idx + 1;
    n_data = (r.kind == K_RD) ? n_rd : r.nbytes;

    // Queue filled at a rising edge, presented at the next falling edge
    @(posedge clk_i);
    tx_q.delete();
    if (r.kind == K_RD) begin
      for (i = 0; i < r.nbytes; i++) tx_q.push_back({(i == r.last_idx), r.data[8*i +: 8]});
    end
    drive_condition(3'b100);
    serve_rx(1'b0, r.hdr);
    if (r.kind == K_MM) begin
      wait_nack();
    end else begin
      serve_tx(1'b1);
      if (r.kind == K_BC) begin
        drive_condition(3'b010);
        serve_rx(1'b0, r.hdr2);
        serve_tx(1'b1);
      end
      // Space in the FIFO again, an overflow stays latched
      rx_fifo_wready_i = 1'b1;
      for (i = 0; i < n_data; i++) begin
        d = r.data[8*i +: 8];
        if (r.kind == K_RD) begin
          serve_tx(1'b0);
          serve_tx(1'b1);
        end else begin
          serve_rx(1'b0, d);
          // Odd parity over data and T-bit, flipped for the corrupted byte
          serve_rx(1'b1, {7'h00, (i == r.bad_idx) ? ^d : ~^d});
        end
      end
    end
    drive_condition(3'b001);
    wait_idle();

    // Expected bit values, ACKs first, then read T-bits
    for (i = 0; i < n_ack; i++) exp_bits.push_back(8'h00);
    for (i = 0; i < n_rd; i++) exp_bits.push_back((i == r.last_idx) ? 8'h00 : 8'h01);

    expect_equal("rx_fifo_wvalid_o count", wr_got.size(), r.exp_wr);
    for (i = 0; i < wr_got.size() && i < r.exp_wr; i++)
      expect_equal("rx_fifo_wdata_o", wr_got[i], r.data[8*i +: 8]);
    expect_equal("bus_tx_req_bit_o count", bit_req_cnt, exp_bits.size());
    expect_equal("tx bit done count", txb_got.size(), exp_bits.size());
    for (i = 0; i < txb_got.size() && i < exp_bits.size(); i++)
      expect_equal("bus_tx_req_value_o bit", txb_got[i], exp_bits[i]);
    expect_equal("tx byte done count", txd_got.size(), n_rd);
    for (i = 0; i < txd_got.size() && i < n_rd; i++)
      expect_equal("bus_tx_req_value_o byte", txd_got[i], r.data[8*i +: 8]);
    expect_equal("tx_fifo_rready_o count", pop_cnt, n_rd);
    expect_equal("event_target_nack_o count", nack_cnt, r.exp_nack);
    expect_equal("parity_err_o count", par_cnt, r.exp_par);
    expect_equal("rx_overflow_err_o count", ovf_cnt, r.exp_ovf);
    expect_equal("rx_last_byte_o count", last_cnt, (r.kind == K_WR) || (r.kind == K_BC));
  endtask

  initial begin
    seed = 32'hfe43_0685;
    errors = 0;
    checks = 0;
    n_rows = 0;
    pop_req = 1'b0;
    bit_req_q = 1'b0;
    rst_ni = 1'b0;
    target_enable_i = 1'b1;
    {bus_start_det_i, bus_rstart_det_i, bus_stop_det_i} = 3'b000;
    bus_rx_done_i = 1'b0;
    bus_rx_data_i = 8'h00;
    bus_tx_done_i = 1'b0;
    rx_fifo_wready_i = 1'b1;
    tx_fifo_rvalid_i = 1'b0;
    tx_fifo_rdata_i = 8'h00;
    tx_last_byte_i = 1'b0;
    target_sta_address_i = STA_ADDR;
    target_dyn_address_i = DYN_ADDR;
    target_sta_address_valid_i = 1'b1;
    target_dyn_address_valid_i = 1'b1;

    // kind, hdr, hdr2, dyn_v, sta_v, wready, nbytes, data, bad, last, wr, nack, par, ovf
    add_row(K_WR, HDR_DYN_W, 8'h00, 1, 1, 1, 3, 32'h000F_3CA5, NONE, NONE, 3, 0, 0, 0);
    add_row(K_RD, HDR_DYN_R, 8'h00, 1, 1, 1, 3, 32'h0081_2211, NONE, 3'd1, 0, 1, 0, 0);
    add_row(K_RD, HDR_DYN_R, 8'h00, 1, 0, 1, 2, 32'h0000_C35A, NONE, NONE, 0, 1, 0, 0);
    add_row(K_MM, 8'h66,     8'h00, 1, 1, 1, 0, 32'h0000_0000, NONE, NONE, 0, 1, 0, 0);
    add_row(K_MM, HDR_STA_W, 8'h00, 0, 0, 1, 0, 32'h0000_0000, NONE, NONE, 0, 1, 0, 0);
    add_row(K_WR, HDR_STA_W, 8'h00, 0, 1, 1, 2, 32'h0000_0196, NONE, NONE, 2, 0, 0, 0);
    add_row(K_MM, HDR_STA_W, 8'h00, 1, 1, 1, 0, 32'h0000_0000, NONE, NONE, 0, 1, 0, 0);
    add_row(K_BC, BCAST_BYTE, HDR_DYN_W, 1, 1, 1, 2, 32'h0000_E77E, NONE, NONE, 2, 0, 0, 0);
    add_row(K_WR, HDR_DYN_W, 8'h00, 1, 1, 1, 3, 32'h0056_3412, 3'd1, NONE, 1, 0, 1, 0);
    add_row(K_WR, HDR_DYN_W, 8'h00, 1, 1, 0, 2, 32'h0000_CDAB, NONE, NONE, 0, 0, 0, 1);

    repeat (5) @(negedge clk_i);
    rst_ni = 1'b1;
    @(negedge clk_i);

    // Quiet outputs after reset
    expect_equal("request outputs",
                 {bus_rx_req_byte_o, bus_rx_req_bit_o, bus_tx_req_byte_o, bus_tx_req_bit_o}, 0);
    expect_equal("rx_fifo_wvalid_o", rx_fifo_wvalid_o, 0);
    expect_equal("tx_fifo_rready_o", tx_fifo_rready_o, 0);
    expect_equal("error outputs", {parity_err_o, rx_overflow_err_o}, 0);
    expect_equal("event outputs", {event_target_nack_o, rx_last_byte_o}, 0);
    expect_equal("target_idle_o", target_idle_o, 1);

    for (int k = 0; k < n_rows; k++) run_row(k);
    end_of_test();
  end

endmodule : tb_i3c_target_ctrl

`default_nettype wire

//--- i3c_target_ctrl.f
hdl/i3c_target_pkg.sv
hdl/xfer_ctrl_if.sv
hdl/target_fsm.sv
hdl/addr_decoder.sv
hdl/rx_datapath.sv
hdl/tx_datapath.sv
hdl/i3c_target_ctrl.sv
test/i3c_target_ctrl_assertions.sv
test/tb_i3c_target_ctrl.sv

//--- Bender.yml
package:
  name: i3c_target_ctrl

sources:
  - hdl/i3c_target_pkg.sv
  - hdl/xfer_ctrl_if.sv
  - hdl/target_fsm.sv
  - hdl/addr_decoder.sv
  - hdl/rx_datapath.sv
  - hdl/tx_datapath.sv
  - hdl/i3c_target_ctrl.sv
  - target: test
    files:
      - test/i3c_target_ctrl_assertions.sv
      - test/tb_i3c_target_ctrl.sv
